// File: source/rvPkg.sv
package rvPkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      regAddr_t;
    typedef logic [7:0]      byteMask_t;
    typedef logic [3:0]      sizeNum_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluPassB,   // lui
        aluNone
    } aluOp_t;

    typedef enum logic [1:0] {
        wbAluResult,
        wbLoadData,
        wbPcPlus4
    } wbSel_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam xlen_t RESET_PC = 64'h0;

endpackage

// File: source/ctrlIf.sv
`timescale 1ns/1ns

interface ctrlIf import rvPkg::*; ();
    aluOp_t    aluOp;
    logic      selA;      // 1: rs1, 0: pc
    logic      selB;      // 1: rs2, 0: imm
    byteMask_t memWmask;  // unshifted size mask
    logic      writeRd;
    logic      pcSel;     // target base, 1: rs1
    logic      npcOp;     // take target
    wbSel_t    wbSel;
    logic      memRen;
    logic      sext;
    sizeNum_t  readNum;
    logic      ebreak;

    modport decode (output aluOp, selA, selB, memWmask, writeRd, pcSel, npcOp,
                    wbSel, memRen, sext, readNum, ebreak);
    modport datapath (input aluOp, selA, selB, memWmask, writeRd, pcSel, npcOp,
                      wbSel, memRen, sext, readNum, ebreak);
endinterface

// File: source/decoder.sv
`timescale 1ns/1ns

module decoder import rvPkg::*; (
    input  inst_t  inst,
    input  xlen_t  rs1,
    input  xlen_t  rs2,
    ctrlIf.decode  ctrl
);

    logic [6:0] opCode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opCode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // safe defaults, nothing written, sequential PC
        ctrl.aluOp    = aluNone;
        ctrl.selA     = 1'b1;
        ctrl.selB     = 1'b0;
        ctrl.memWmask = 8'h00;
        ctrl.writeRd  = 1'b0;
        ctrl.pcSel    = 1'b0;
        ctrl.npcOp    = 1'b0;
        ctrl.wbSel    = wbAluResult;
        ctrl.memRen   = 1'b0;
        ctrl.sext     = 1'b0;
        ctrl.readNum  = 4'd8;
        ctrl.ebreak   = 1'b0;

        case (opCode)
            OP_REG: begin
                ctrl.selB    = 1'b1;
                ctrl.writeRd = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = (funct7 == 7'h20) ? aluSub : aluAdd;
                    3'b001: ctrl.aluOp = aluSll;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b111: ctrl.aluOp = aluAnd;
                    default: ctrl.aluOp = (funct7 == 7'h00) ? aluSrl : aluNone;
                endcase
                // only sub may set funct7
                if (!(funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000)))
                    ctrl.writeRd = 1'b0;
            end
            OP_IMM: begin
                ctrl.writeRd = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAdd;
                    3'b001: ctrl.aluOp = aluSll;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b111: ctrl.aluOp = aluAnd;
                    default: ctrl.aluOp = aluSrl;
                endcase
                if (funct3 == 3'b101 && funct7[6:1] != 6'h00)
                    ctrl.writeRd = 1'b0;  // srai not supported
            end
            OP_AUIPC: begin
                ctrl.selA    = 1'b0;
                ctrl.aluOp   = aluAdd;
                ctrl.writeRd = 1'b1;
            end
            OP_LUI: begin
                ctrl.aluOp   = aluPassB;
                ctrl.writeRd = 1'b1;
            end
            OP_LOAD: begin
                ctrl.aluOp = aluAdd;  // rs1 + imm
                ctrl.wbSel = wbLoadData;
                ctrl.sext  = ~funct3[2];
                case (funct3[1:0])
                    2'b00:   ctrl.readNum = 4'd1;
                    2'b01:   ctrl.readNum = 4'd2;
                    2'b10:   ctrl.readNum = 4'd4;
                    default: ctrl.readNum = 4'd8;
                endcase
                if (funct3 <= 3'd5) begin
                    ctrl.memRen  = 1'b1;
                    ctrl.writeRd = 1'b1;
                end
            end
            OP_STORE: begin
                ctrl.aluOp = aluAdd;
                case (funct3)
                    3'b000:  ctrl.memWmask = 8'h01;
                    3'b001:  ctrl.memWmask = 8'h03;
                    3'b010:  ctrl.memWmask = 8'h0f;
                    3'b011:  ctrl.memWmask = 8'hff;
                    default: ctrl.memWmask = 8'h00;
                endcase
            end
            OP_JAL: begin
                ctrl.writeRd = 1'b1;
                ctrl.npcOp   = 1'b1;
                ctrl.wbSel   = wbPcPlus4;
            end
            OP_JALR: begin
                ctrl.writeRd = 1'b1;
                ctrl.pcSel   = 1'b1;
                ctrl.npcOp   = 1'b1;
                ctrl.wbSel   = wbPcPlus4;
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.npcOp = (rs1 == rs2);
                    3'b001:  ctrl.npcOp = (rs1 != rs2);
                    3'b100:  ctrl.npcOp = ($signed(rs1) < $signed(rs2));
                    3'b101:  ctrl.npcOp = ($signed(rs1) >= $signed(rs2));
                    3'b110:  ctrl.npcOp = (rs1 < rs2);
                    3'b111:  ctrl.npcOp = (rs1 >= rs2);
                    default: ctrl.npcOp = 1'b0;
                endcase
            end
            OP_SYSTEM: begin
                ctrl.ebreak = (funct3 == 3'b000) && (inst[31:20] == 12'h001);
            end
            default: ;
        endcase
    end

endmodule

// File: source/immGen.sv
`timescale 1ns/1ns

module immGen import rvPkg::*; (
    input  inst_t inst,
    output xlen_t imm
);

    logic [6:0] opCode;

    assign opCode = inst[6:0];

    always_comb begin
        case (opCode)
            OP_IMM, OP_LOAD, OP_JALR, OP_SYSTEM: begin
                imm = {{52{inst[31]}}, inst[31:20]};
            end
            OP_STORE: begin
                imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                // B-type, bit 0 implied zero
                imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {{32{inst[31]}}, inst[31:12], 12'h000};
            end
            OP_JAL: begin
                imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ns

module alu import rvPkg::*; (
    input  aluOp_t op,
    input  xlen_t  a,
    input  xlen_t  b,
    output xlen_t  result
);

    logic [5:0] shamt;

    assign shamt = b[5:0];  // rv64 shift amount

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluXor:   result = a ^ b;
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSlt: begin
                result = {63'b0, $signed(a) < $signed(b)};
            end
            aluSltu: begin
                result = {63'b0, a < b};
            end
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ns

module regFile import rvPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    input  regAddr_t rdAddr,
    input  logic     writeEn,
    input  xlen_t    rdData,
    output xlen_t    rs1Data,
    output xlen_t    rs2Data
);

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst && writeEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// File: source/pcUnit.sv
`timescale 1ns/1ns

module pcUnit import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    ctrlIf.datapath ctrl,
    input  xlen_t   rs1,
    input  xlen_t   imm,
    output xlen_t   pc,
    output xlen_t   pcPlus4,
    output logic    halted
);

    xlen_t targetBase;
    xlen_t target;
    xlen_t nextPc;

    assign pcPlus4    = pc + 64'd4;
    assign targetBase = ctrl.pcSel ? rs1 : pc;
    assign target     = (targetBase + imm) & ~{63'b0, ctrl.pcSel};  // jalr clears bit 0
    assign nextPc     = ctrl.npcOp ? target : pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ctrl.ebreak) begin
                halted <= 1'b1;  // pc stays on the ebreak
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

// File: source/lsu.sv
`timescale 1ns/1ns

module lsu import rvPkg::*; (
    input  logic    rst,
    ctrlIf.datapath ctrl,
    input  xlen_t   addr,
    input  xlen_t   storeData,
    output xlen_t   memWdata,
    output byteMask_t memWmask,
    output logic    memRen,
    input  xlen_t   memRdata,
    output xlen_t   loadData
);

    logic [2:0] laneOffset;
    logic [5:0] bitOffset;
    xlen_t      shiftedRdata;

    assign laneOffset = addr[2:0];
    assign bitOffset  = {laneOffset, 3'b000};

    // store side, move into byte lanes
    assign memWmask = rst ? 8'h00 : byteMask_t'(ctrl.memWmask << laneOffset);
    assign memWdata = storeData << bitOffset;
    assign memRen   = ctrl.memRen & ~rst;

    // load side, bring addressed byte down to lane 0
    assign shiftedRdata = memRdata >> bitOffset;

    always_comb begin
        case (ctrl.readNum)
            4'd1: begin
                loadData = {{56{ctrl.sext & shiftedRdata[7]}}, shiftedRdata[7:0]};
            end
            4'd2: begin
                loadData = {{48{ctrl.sext & shiftedRdata[15]}}, shiftedRdata[15:0]};
            end
            4'd4: begin
                loadData = {{32{ctrl.sext & shiftedRdata[31]}}, shiftedRdata[31:0]};
            end
            default: begin
                loadData = shiftedRdata;
            end
        endcase
    end

endmodule

// File: source/coreTop.sv
`timescale 1ns/1ns

module coreTop import rvPkg::*; (
    input  logic      clk,
    input  logic      rst,
    output xlen_t     pc,
    input  inst_t     inst,
    output xlen_t     memAddr,
    output xlen_t     memWdata,
    output byteMask_t memWmask,
    output logic      memRen,
    input  xlen_t     memRdata,
    output logic      halted
);

    ctrlIf ctrlBus ();

    xlen_t rs1Data;
    xlen_t rs2Data;
    xlen_t imm;
    xlen_t opA;
    xlen_t opB;
    xlen_t aluResult;
    xlen_t loadData;
    xlen_t pcPlus4;
    xlen_t rdData;
    logic  writeEn;

    decoder u_decoder (.inst(inst), .rs1(rs1Data), .rs2(rs2Data), .ctrl(ctrlBus.decode));

    immGen u_immGen (.inst(inst), .imm(imm));

    assign opA = ctrlBus.selA ? rs1Data : pc;
    assign opB = ctrlBus.selB ? rs2Data : imm;

    alu u_alu (.op(ctrlBus.aluOp), .a(opA), .b(opB), .result(aluResult));

    always_comb begin
        case (ctrlBus.wbSel)
            wbLoadData: rdData = loadData;
            wbPcPlus4:  rdData = pcPlus4;  // link value
            default:    rdData = aluResult;
        endcase
    end

    assign writeEn = ctrlBus.writeRd & ~halted;

    regFile u_regFile (
        .clk(clk), .rst(rst),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
        .writeEn(writeEn), .rdData(rdData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    pcUnit u_pcUnit (
        .clk(clk), .rst(rst), .ctrl(ctrlBus.datapath),
        .rs1(rs1Data), .imm(imm),
        .pc(pc), .pcPlus4(pcPlus4), .halted(halted)
    );

    assign memAddr = aluResult;  // rs1 + imm for loads and stores

    lsu u_lsu (
        .rst(rst), .ctrl(ctrlBus.datapath),
        .addr(aluResult), .storeData(rs2Data),
        .memWdata(memWdata), .memWmask(memWmask), .memRen(memRen),
        .memRdata(memRdata), .loadData(loadData)
    );

endmodule

// File: sim/coreAssert_assert.sv
`timescale 1ns/1ns

module coreAssert import rvPkg::*; (
    input logic      clk,
    input logic      rst,
    input xlen_t     pc,
    input byteMask_t memWmask,
    input logic      halted
);

    logic [8:0] maskSum;

    // adding the lowest set bit collapses a contiguous run into one bit
    assign maskSum = {1'b0, memWmask} + {1'b0, memWmask & (~memWmask + 8'd1)};

    maskInReset: assert property (@(posedge clk) rst |-> memWmask == 8'h00)
        else $error("memWmask active during reset");

    maskLegal: assert property (@(posedge clk) disable iff (rst)
        memWmask == 8'h00 || ((maskSum & (maskSum - 9'd1)) == 9'd0
        && $countones(memWmask) inside {1, 2, 4, 8}))
        else $error("illegal byte mask %h", memWmask);

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    pcFrozen: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

bind coreTop coreAssert u_coreAssert (
    .clk(clk), .rst(rst), .pc(pc), .memWmask(memWmask), .halted(halted)
);

// File: sim/tbCore.sv
`timescale 1ns/1ns

module tbCore import rvPkg::*; ();

    logic      clk;
    logic      rst;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     memAddr;
    xlen_t     memWdata;
    byteMask_t memWmask;
    logic      memRen;
    xlen_t     memRdata;
    logic      halted;

    inst_t imem [128];
    xlen_t dmem [128];
    int    progLen;
    int    loadCount = 0;

    xlen_t     logAddr [$];
    xlen_t     logData [$];
    byteMask_t logMask [$];
    xlen_t     expAddr [$];
    xlen_t     expData [$];
    byteMask_t expMask [$];

    coreTop DUT (.*);

    always #2 clk = ~clk;

    always @(negedge clk) inst <= imem[pc[8:2]];  // fetch for the next edge

    assign memRdata = dmem[memAddr[9:3]];

    always @(posedge clk) begin
        xlen_t laneData;
        laneData = '0;
        if (!rst && memRen)
            loadCount++;
        if (!rst && memWmask != 8'h00) begin
            for (int b = 0; b < 8; b++) begin
                if (memWmask[b]) begin
                    dmem[memAddr[9:3]][8*b +: 8] <= memWdata[8*b +: 8];
                    laneData[8*b +: 8] = memWdata[8*b +: 8];
                end
            end
            logAddr.push_back(memAddr);
            logData.push_back(laneData);
            logMask.push_back(memWmask);
        end
    end

    function automatic inst_t rType(logic [6:0] f7, logic [2:0] f3, regAddr_t rd,
                                    regAddr_t rs1, regAddr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t iType(logic [6:0] op, logic [2:0] f3, regAddr_t rd,
                                    regAddr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t sType(logic [2:0] f3, regAddr_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE};  // base is always x0
    endfunction

    function automatic inst_t bType(logic [2:0] f3, regAddr_t rs1, regAddr_t rs2);
        return {1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, OP_BRANCH};  // offset +8
    endfunction

    task automatic emit(inst_t word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(xlen_t addr, xlen_t data, byteMask_t mask);
        expAddr.push_back(addr);
        expData.push_back(data);
        expMask.push_back(mask);
    endtask

    task automatic failNow(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkValue(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            failNow("stopping at first mismatch");
        end
    endtask

    task automatic branchTriple(logic [2:0] f3, regAddr_t ntA, regAddr_t ntB);
        emit(bType(f3, ntA, ntB));  // not taken
        emit(bType(f3, ntB, ntA));  // taken, skips the bad store
        emit(sType(3'd3, 5'd0, 12'h1f8));
    endtask

    initial begin
        int cycles;
        clk = 1'b0;
        rst = 1'b1;
        inst = '0;
        progLen = 0;
        for (int i = 0; i < 128; i++) begin
            imem[i] = sType(3'd3, 5'd0, {2'b01, 7'(i), 3'b000});  // stray store per word
            dmem[i] = {32'ha5a50000, 32'(i)};
        end
        dmem[64] = 64'hf0e1d2c3b4a59687;  // load source at 0x200

        emit(iType(OP_IMM, 3'd0, 5'd1, 5'd0, 12'hffb));
        emit(iType(OP_IMM, 3'd0, 5'd2, 5'd0, 12'h00c));
        emit(rType(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd3, 12'h100));
        emit(rType(7'h20, 3'd0, 5'd4, 5'd2, 5'd1));
        emit(sType(3'd3, 5'd4, 12'h108));
        emit(rType(7'h00, 3'd4, 5'd5, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd5, 12'h110));
        emit(rType(7'h00, 3'd6, 5'd6, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd6, 12'h118));
        emit(rType(7'h00, 3'd7, 5'd7, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd7, 12'h120));
        emit(rType(7'h00, 3'd1, 5'd8, 5'd2, 5'd2));
        emit(sType(3'd3, 5'd8, 12'h128));
        emit(rType(7'h00, 3'd5, 5'd9, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd9, 12'h130));
        emit(rType(7'h00, 3'd2, 5'd10, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd10, 12'h138));
        emit(rType(7'h00, 3'd3, 5'd11, 5'd1, 5'd2));
        emit(sType(3'd3, 5'd11, 12'h140));
        emit(iType(OP_LOAD, 3'd0, 5'd12, 5'd0, 12'h203));
        emit(sType(3'd3, 5'd12, 12'h148));
        emit(iType(OP_LOAD, 3'd1, 5'd13, 5'd0, 12'h206));
        emit(sType(3'd3, 5'd13, 12'h150));
        emit(iType(OP_LOAD, 3'd2, 5'd14, 5'd0, 12'h204));
        emit(sType(3'd3, 5'd14, 12'h158));
        emit(iType(OP_LOAD, 3'd3, 5'd15, 5'd0, 12'h200));
        emit(sType(3'd3, 5'd15, 12'h160));
        emit(iType(OP_LOAD, 3'd4, 5'd16, 5'd0, 12'h201));
        emit(sType(3'd3, 5'd16, 12'h168));
        emit(iType(OP_LOAD, 3'd5, 5'd17, 5'd0, 12'h202));
        emit(sType(3'd3, 5'd17, 12'h170));
        emit(sType(3'd0, 5'd15, 12'h183));
        emit(sType(3'd1, 5'd15, 12'h186));
        emit(sType(3'd2, 5'd15, 12'h184));
        branchTriple(3'd0, 5'd1, 5'd2);  // beq, second pair swapped below
        imem[progLen-2] = bType(3'd0, 5'd3, 5'd3);
        branchTriple(3'd1, 5'd3, 5'd3);
        imem[progLen-2] = bType(3'd1, 5'd1, 5'd2);
        branchTriple(3'd4, 5'd2, 5'd1);  // -5 < 12 signed
        branchTriple(3'd5, 5'd1, 5'd2);
        branchTriple(3'd6, 5'd1, 5'd2);  // unsigned order flips
        branchTriple(3'd7, 5'd2, 5'd1);
        emit(sType(3'd3, 5'd3, 12'h1a0));
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd18, OP_JAL});  // pc 0xd8, +8
        emit(sType(3'd3, 5'd0, 12'h1f8));
        emit(sType(3'd3, 5'd18, 12'h1a8));
        emit(iType(OP_IMM, 3'd0, 5'd19, 5'd0, 12'h0f1));
        emit(iType(OP_JALR, 3'd0, 5'd20, 5'd19, 12'h000));  // pc 0xe8
        emit(sType(3'd3, 5'd0, 12'h1f8));
        emit(sType(3'd3, 5'd20, 12'h1b0));
        emit({20'h80000, 5'd21, OP_LUI});
        emit(sType(3'd3, 5'd21, 12'h1b8));
        emit({20'h00001, 5'd22, OP_AUIPC});  // pc 0xfc
        emit(sType(3'd3, 5'd22, 12'h1c0));
        emit(32'h00100073);  // ebreak at 0x104

        expectStore(64'h100, 64'h7, 8'hff);
        expectStore(64'h108, 64'h11, 8'hff);
        expectStore(64'h110, 64'hfffffffffffffff7, 8'hff);
        expectStore(64'h118, 64'hffffffffffffffff, 8'hff);
        expectStore(64'h120, 64'h8, 8'hff);
        expectStore(64'h128, 64'hc000, 8'hff);
        expectStore(64'h130, 64'h000fffffffffffff, 8'hff);
        expectStore(64'h138, 64'h1, 8'hff);
        expectStore(64'h140, 64'h0, 8'hff);
        expectStore(64'h148, 64'hffffffffffffffb4, 8'hff);
        expectStore(64'h150, 64'hfffffffffffff0e1, 8'hff);
        expectStore(64'h158, 64'hfffffffff0e1d2c3, 8'hff);
        expectStore(64'h160, 64'hf0e1d2c3b4a59687, 8'hff);
        expectStore(64'h168, 64'h96, 8'hff);
        expectStore(64'h170, 64'hb4a5, 8'hff);
        expectStore(64'h183, 64'h0000000087000000, 8'h08);
        expectStore(64'h186, 64'h9687000000000000, 8'hc0);
        expectStore(64'h184, 64'hb4a5968700000000, 8'hf0);
        expectStore(64'h1a0, 64'h7, 8'hff);
        expectStore(64'h1a8, 64'hdc, 8'hff);
        expectStore(64'h1b0, 64'hec, 8'hff);
        expectStore(64'h1b8, 64'hffffffff80000000, 8'hff);
        expectStore(64'h1c0, 64'h10fc, 8'hff);

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < expAddr.size(); i++) begin
            cycles = 0;
            while (logAddr.size() == 0 && cycles < 200) begin
                @(negedge clk);
                cycles++;
            end
            if (logAddr.size() == 0)
                failNow($sformatf("no store seen for table entry %0d", i));
            checkValue("memAddr", logAddr.pop_front(), expAddr[i]);
            checkValue("memWdata", logData.pop_front(), expData[i]);
            checkValue("memWmask", 64'(logMask.pop_front()), 64'(expMask[i]));
        end

        cycles = 0;
        while (!halted && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted)
            failNow("core never halted after ebreak");
        repeat (20) begin
            @(negedge clk);
            checkValue("pc", pc, 64'h104);
            checkValue("extra stores", 64'(logAddr.size()), 64'h0);
        end
        checkValue("memRen", 64'(loadCount), 64'd6);  // one read cycle per load
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: all.f
source/rvPkg.sv
source/ctrlIf.sv
source/decoder.sv
source/immGen.sv
source/alu.sv
source/regFile.sv
source/pcUnit.sv
source/lsu.sv
source/coreTop.sv
sim/coreAssert_assert.sv
sim/tbCore.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tbCore -f all.f -o tbCore
	-./obj_dir/tbCore > sim.log 2>&1
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
